/* source/ex_pkg.sv */
package ex_pkg;

	localparam int XLEN = 64;

	typedef logic [XLEN-1:0] xlen_t;   // register data word
	typedef logic [XLEN-1:0] addr_t;   // instruction address
	typedef logic [4:0]      reg_addr_t;
	typedef logic [6:0]      opcode_t;
	typedef logic [2:0]      funct3_t;
	typedef logic [6:0]      funct7_t;
	typedef logic [19:0]     imm_t;    // [11:0] for I/B, all bits for U/J
	typedef logic [5:0]      shamt_t;

	localparam opcode_t OPC_I_IMM  = 7'b0010011;
	localparam opcode_t OPC_I_WORD = 7'b0011011;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_R      = 7'b0110011;
	localparam opcode_t OPC_R_WORD = 7'b0111011;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;

	// alu operations, shared by register and immediate forms
	localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
	localparam funct3_t FUNCT3_SLL     = 3'b001;
	localparam funct3_t FUNCT3_SLT     = 3'b010;
	localparam funct3_t FUNCT3_SLTU    = 3'b011;
	localparam funct3_t FUNCT3_XOR     = 3'b100;
	localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
	localparam funct3_t FUNCT3_OR      = 3'b110;
	localparam funct3_t FUNCT3_AND     = 3'b111;

	// branch conditions
	localparam funct3_t FUNCT3_BEQ  = 3'b000;
	localparam funct3_t FUNCT3_BNE  = 3'b001;
	localparam funct3_t FUNCT3_BLT  = 3'b100;
	localparam funct3_t FUNCT3_BGE  = 3'b101;
	localparam funct3_t FUNCT3_BLTU = 3'b110;
	localparam funct3_t FUNCT3_BGEU = 3'b111;

	localparam funct7_t    FUNCT7_BASE = 7'b0000000;
	localparam funct7_t    FUNCT7_ALT  = 7'b0100000;   // sub, sra
	localparam logic [5:0] FUNCT6_SRL  = 6'b000000;
	localparam logic [5:0] FUNCT6_SRA  = 6'b010000;

	localparam reg_addr_t REG_ZERO   = 5'd0;
	localparam addr_t     INVALID_PC = '0;

endpackage

/* source/ex_operand_fwd.sv */
`timescale 1ns/1ps

module ex_operand_fwd (
	input  ex_pkg::reg_addr_t rs1_addr_i,
	input  ex_pkg::reg_addr_t rs2_addr_i,
	input  ex_pkg::xlen_t     rs1_data_i,
	input  ex_pkg::xlen_t     rs2_data_i,
	input  ex_pkg::xlen_t     mem_wdata_i,
	input  ex_pkg::reg_addr_t mem_rd_addr_i,
	input  logic              mem_wreg_i,
	output ex_pkg::xlen_t     rs1_val_o,
	output ex_pkg::xlen_t     rs2_val_o
);
	import ex_pkg::*;

	// x0 is hardwired, a write to it never forwards
	function automatic logic fwd_hit(input reg_addr_t addr, input reg_addr_t wr_addr,
			input logic wr_en);
		fwd_hit = wr_en && (addr == wr_addr) && (addr != REG_ZERO);
	endfunction

	logic rs1_hit;
	logic rs2_hit;

	assign rs1_hit = fwd_hit(rs1_addr_i, mem_rd_addr_i, mem_wreg_i);
	assign rs2_hit = fwd_hit(rs2_addr_i, mem_rd_addr_i, mem_wreg_i);

	assign rs1_val_o = rs1_hit ? mem_wdata_i : rs1_data_i;   // mem stage result
	assign rs2_val_o = rs2_hit ? mem_wdata_i : rs2_data_i;

endmodule

/* source/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
	input  ex_pkg::opcode_t opcode_i,
	input  ex_pkg::funct3_t funct3_i,
	input  ex_pkg::funct7_t funct7_i,
	input  ex_pkg::imm_t    imm_i,
	input  ex_pkg::addr_t   pc_i,
	input  ex_pkg::xlen_t   rs1_val_i,
	input  ex_pkg::xlen_t   rs2_val_i,
	input  logic            wreg_i,
	output ex_pkg::xlen_t   wdata_o,
	output logic            wreg_o
);
	import ex_pkg::*;

	function automatic xlen_t sext_w(input logic [31:0] w);
		sext_w = {{(XLEN-32){w[31]}}, w};
	endfunction

	xlen_t      imm_sx;      // sign-extended imm[11:0]
	xlen_t      upper_imm;   // lui/auipc operand
	shamt_t     shamt;
	logic [5:0] funct6;
	xlen_t      sum_ri;
	xlen_t      sum_rr;
	xlen_t      diff_rr;

	assign imm_sx    = {{(XLEN-12){imm_i[11]}}, imm_i[11:0]};
	assign upper_imm = {{(XLEN-32){imm_i[19]}}, imm_i, 12'h000};
	assign shamt     = imm_i[5:0];
	assign funct6    = funct7_i[6:1];
	assign sum_ri    = rs1_val_i + imm_sx;
	assign sum_rr    = rs1_val_i + rs2_val_i;
	assign diff_rr   = rs1_val_i - rs2_val_i;

	always_comb begin
		wdata_o = '0;   // unknown encodings write 0
		case (opcode_i)
			OPC_I_IMM: begin
				case (funct3_i)
					FUNCT3_ADD_SUB: wdata_o = sum_ri;
					FUNCT3_SLL:     wdata_o = rs1_val_i << shamt;
					FUNCT3_SLT:     wdata_o = xlen_t'($signed(rs1_val_i) < $signed(imm_sx));
					FUNCT3_SLTU:    wdata_o = xlen_t'(rs1_val_i < imm_sx);
					FUNCT3_XOR:     wdata_o = rs1_val_i ^ imm_sx;
					FUNCT3_OR:      wdata_o = rs1_val_i | imm_sx;
					FUNCT3_AND:     wdata_o = rs1_val_i & imm_sx;
					FUNCT3_SRL_SRA: begin
						if (funct6 == FUNCT6_SRL)
							wdata_o = rs1_val_i >> shamt;
						else if (funct6 == FUNCT6_SRA)
							wdata_o = $signed(rs1_val_i) >>> shamt;
					end
					default: wdata_o = '0;
				endcase
			end
			OPC_I_WORD: begin
				case (funct3_i)
					FUNCT3_ADD_SUB: wdata_o = sext_w(sum_ri[31:0]);
					FUNCT3_SLL:     wdata_o = sext_w(rs1_val_i[31:0] << shamt[4:0]);
					FUNCT3_SRL_SRA: begin
						if (funct6 == FUNCT6_SRL)
							wdata_o = sext_w(rs1_val_i[31:0] >> shamt[4:0]);
						else if (funct6 == FUNCT6_SRA)
							wdata_o = sext_w($signed(rs1_val_i[31:0]) >>> shamt[4:0]);
					end
					default: wdata_o = '0;
				endcase
			end
			OPC_R: begin
				if (funct7_i == FUNCT7_BASE) begin
					case (funct3_i)
						FUNCT3_ADD_SUB: wdata_o = sum_rr;
						FUNCT3_SLL:     wdata_o = rs1_val_i << rs2_val_i[5:0];
						FUNCT3_SLT:     wdata_o = xlen_t'($signed(rs1_val_i) < $signed(rs2_val_i));
						FUNCT3_SLTU:    wdata_o = xlen_t'(rs1_val_i < rs2_val_i);
						FUNCT3_XOR:     wdata_o = rs1_val_i ^ rs2_val_i;
						FUNCT3_SRL_SRA: wdata_o = rs1_val_i >> rs2_val_i[5:0];
						FUNCT3_OR:      wdata_o = rs1_val_i | rs2_val_i;
						FUNCT3_AND:     wdata_o = rs1_val_i & rs2_val_i;
						default:        wdata_o = '0;
					endcase
				end else if (funct7_i == FUNCT7_ALT) begin
					if (funct3_i == FUNCT3_ADD_SUB)
						wdata_o = diff_rr;
					else if (funct3_i == FUNCT3_SRL_SRA)
						wdata_o = $signed(rs1_val_i) >>> rs2_val_i[5:0];
				end
			end
			OPC_R_WORD: begin
				if (funct7_i == FUNCT7_BASE) begin
					case (funct3_i)
						FUNCT3_ADD_SUB: wdata_o = sext_w(sum_rr[31:0]);
						FUNCT3_SLL:     wdata_o = sext_w(rs1_val_i[31:0] << rs2_val_i[4:0]);
						FUNCT3_SRL_SRA: wdata_o = sext_w(rs1_val_i[31:0] >> rs2_val_i[4:0]);
						default:        wdata_o = '0;
					endcase
				end else if (funct7_i == FUNCT7_ALT) begin
					if (funct3_i == FUNCT3_ADD_SUB)
						wdata_o = sext_w(diff_rr[31:0]);
					else if (funct3_i == FUNCT3_SRL_SRA)
						wdata_o = sext_w($signed(rs1_val_i[31:0]) >>> rs2_val_i[4:0]);
				end
			end
			OPC_LUI:   wdata_o = upper_imm;
			OPC_AUIPC: wdata_o = pc_i + upper_imm;
			OPC_JAL,
			OPC_JALR:  wdata_o = pc_i + 64'd4;   // link address
			default:   wdata_o = '0;
		endcase
	end

	// sraiw/srliw with shamt[5] set are illegal, drop the write
	assign wreg_o = (opcode_i == OPC_I_WORD && funct3_i == FUNCT3_SRL_SRA && shamt[5])
			? 1'b0 : wreg_i;

endmodule

/* source/ex_branch.sv */
`timescale 1ns/1ps

module ex_branch (
	input  ex_pkg::opcode_t opcode_i,
	input  ex_pkg::funct3_t funct3_i,
	input  ex_pkg::imm_t    imm_i,
	input  ex_pkg::addr_t   pc_i,
	input  ex_pkg::xlen_t   rs1_val_i,
	input  ex_pkg::xlen_t   rs2_val_i,
	output logic            branch_flag_o,
	output ex_pkg::addr_t   pc_new_o
);
	import ex_pkg::*;

	addr_t off_b;      // branch offset, imm doubled
	addr_t off_j;      // jal offset
	xlen_t jalr_sum;
	logic  cond;

	assign off_b    = {{(XLEN-13){imm_i[11]}}, imm_i[11:0], 1'b0};
	assign off_j    = {{(XLEN-21){imm_i[19]}}, imm_i, 1'b0};
	assign jalr_sum = rs1_val_i + {{(XLEN-12){imm_i[11]}}, imm_i[11:0]};

	always_comb begin
		case (funct3_i)
			FUNCT3_BEQ:  cond = (rs1_val_i == rs2_val_i);
			FUNCT3_BNE:  cond = (rs1_val_i != rs2_val_i);
			FUNCT3_BLT:  cond = ($signed(rs1_val_i) < $signed(rs2_val_i));
			FUNCT3_BGE:  cond = ($signed(rs1_val_i) >= $signed(rs2_val_i));
			FUNCT3_BLTU: cond = (rs1_val_i < rs2_val_i);
			FUNCT3_BGEU: cond = (rs1_val_i >= rs2_val_i);
			default:     cond = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode_i)
			OPC_BRANCH: begin
				branch_flag_o = cond;
				pc_new_o      = pc_i + off_b;   // target shown even if not taken
			end
			OPC_JAL: begin
				branch_flag_o = 1'b1;
				pc_new_o      = pc_i + off_j;
			end
			OPC_JALR: begin
				branch_flag_o = 1'b1;
				pc_new_o      = {jalr_sum[XLEN-1:1], 1'b0};
			end
			default: begin
				branch_flag_o = 1'b0;
				pc_new_o      = INVALID_PC;
			end
		endcase
	end

endmodule

/* source/ex_out_reg.sv */
`timescale 1ns/1ps

module ex_out_reg (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              valid_i,
	input  ex_pkg::reg_addr_t rd_addr_i,
	input  ex_pkg::xlen_t     wdata_i,
	input  logic              wreg_i,
	input  logic              branch_flag_i,
	input  ex_pkg::addr_t     pc_new_i,
	output logic              valid_o,
	output ex_pkg::reg_addr_t rd_addr_o,
	output ex_pkg::xlen_t     wdata_o,
	output logic              wreg_o,
	output logic              branch_flag_o,
	output ex_pkg::addr_t     pc_new_o
);
	import ex_pkg::*;

	// strobe delayed by one cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_addr_o     <= REG_ZERO;
			wdata_o       <= '0;
			wreg_o        <= 1'b0;
			branch_flag_o <= 1'b0;
			pc_new_o      <= INVALID_PC;
		end else if (valid_i) begin   // hold between strobes
			rd_addr_o     <= rd_addr_i;
			wdata_o       <= wdata_i;
			wreg_o        <= wreg_i;
			branch_flag_o <= branch_flag_i;
			pc_new_o      <= pc_new_i;
		end
	end

endmodule

/* source/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              valid_i,
	input  ex_pkg::opcode_t   opcode_i,
	input  ex_pkg::funct3_t   funct3_i,
	input  ex_pkg::funct7_t   funct7_i,
	input  ex_pkg::reg_addr_t rs1_addr_i,
	input  ex_pkg::reg_addr_t rs2_addr_i,
	input  ex_pkg::xlen_t     rs1_data_i,
	input  ex_pkg::xlen_t     rs2_data_i,
	input  ex_pkg::reg_addr_t rd_addr_i,
	input  logic              wreg_i,
	input  ex_pkg::imm_t      imm_i,
	input  ex_pkg::addr_t     pc_i,
	input  ex_pkg::xlen_t     mem_wdata_i,     // mem stage write-back, for forwarding
	input  ex_pkg::reg_addr_t mem_rd_addr_i,
	input  logic              mem_wreg_i,
	output logic              valid_o,
	output ex_pkg::reg_addr_t rd_addr_o,
	output logic              wreg_o,
	output ex_pkg::xlen_t     wdata_o,
	output logic              branch_flag_o,
	output ex_pkg::addr_t     pc_new_o
);
	import ex_pkg::*;

	xlen_t rs1_val;
	xlen_t rs2_val;
	xlen_t alu_wdata;
	logic  alu_wreg;
	logic  br_flag;
	addr_t br_pc;

	ex_operand_fwd u_fwd (.rs1_addr_i(rs1_addr_i), .rs2_addr_i(rs2_addr_i),
		.rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i), .mem_wdata_i(mem_wdata_i),
		.mem_rd_addr_i(mem_rd_addr_i), .mem_wreg_i(mem_wreg_i),
		.rs1_val_o(rs1_val), .rs2_val_o(rs2_val));

	ex_alu u_alu (.opcode_i(opcode_i), .funct3_i(funct3_i), .funct7_i(funct7_i),
		.imm_i(imm_i), .pc_i(pc_i), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
		.wreg_i(wreg_i), .wdata_o(alu_wdata), .wreg_o(alu_wreg));

	ex_branch u_branch (.opcode_i(opcode_i), .funct3_i(funct3_i), .imm_i(imm_i),
		.pc_i(pc_i), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
		.branch_flag_o(br_flag), .pc_new_o(br_pc));

	ex_out_reg u_out (.clk(clk), .rst_n_i(rst_n_i), .valid_i(valid_i),
		.rd_addr_i(rd_addr_i), .wdata_i(alu_wdata), .wreg_i(alu_wreg),
		.branch_flag_i(br_flag), .pc_new_i(br_pc), .valid_o(valid_o),
		.rd_addr_o(rd_addr_o), .wdata_o(wdata_o), .wreg_o(wreg_o),
		.branch_flag_o(branch_flag_o), .pc_new_o(pc_new_o));

endmodule

/* tests/ex_top_assert.sv */
`timescale 1ns/1ps

module ex_top_assert (
	input logic clk,
	input logic rst_n_i,
	input logic valid_i,
	input logic valid_o,
	input logic branch_flag_o
);
	int   fail_count = 0;   // failed assertions since time 0
	logic seen_valid;       // a result has left the stage since reset

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			seen_valid <= 1'b0;
		else if (valid_o)
			seen_valid <= 1'b1;
	end

	assert property (@(posedge clk) !rst_n_i |-> !valid_o)
		else begin
			$error("valid_o high during reset");
			fail_count++;
		end

	// strobe out exactly one cycle after strobe in
	assert property (@(posedge clk) disable iff (!rst_n_i) valid_i |=> valid_o)
		else begin
			$error("valid_o missing after valid_i");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n_i) !valid_i |=> !valid_o)
		else begin
			$error("valid_o without valid_i");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n_i)
			branch_flag_o |-> (seen_valid || valid_o))
		else begin
			$error("branch_flag_o before any valid_o");
			fail_count++;
		end

endmodule

bind ex_top ex_top_assert u_assert (.clk(clk), .rst_n_i(rst_n_i), .valid_i(valid_i),
	.valid_o(valid_o), .branch_flag_o(branch_flag_o));

/* tests/tb_ex_top.sv */
`timescale 1ns/1ps

module tb_ex_top;
	import ex_pkg::*;

	localparam int  NUM_VEC  = 36;
	localparam int  PERIOD   = 40;
	localparam int  VEC_BITS = 472;
	localparam time WATCHDOG = (NUM_VEC * 5 + 30) * PERIOD;

	logic      clk;
	logic      rst_n_i;
	logic      valid_i;
	opcode_t   opcode_i;
	funct3_t   funct3_i;
	funct7_t   funct7_i;
	reg_addr_t rs1_addr_i;
	reg_addr_t rs2_addr_i;
	xlen_t     rs1_data_i;
	xlen_t     rs2_data_i;
	reg_addr_t rd_addr_i;
	logic      wreg_i;
	imm_t      imm_i;
	addr_t     pc_i;
	xlen_t     mem_wdata_i;
	reg_addr_t mem_rd_addr_i;
	logic      mem_wreg_i;
	logic      valid_o;
	reg_addr_t rd_addr_o;
	logic      wreg_o;
	xlen_t     wdata_o;
	logic      branch_flag_o;
	addr_t     pc_new_o;

	logic [VEC_BITS-1:0] patterns [0:NUM_VEC-1];
	int        seed = 32'h3879_d11b;
	int        gap;
	reg_addr_t exp_rd;   // last expected results, also used for the hold checks
	xlen_t     exp_wdata;
	logic      exp_wreg;
	logic      exp_br;
	addr_t     exp_pc;

	ex_top ex_top_inst (.clk(clk), .rst_n_i(rst_n_i), .valid_i(valid_i), .opcode_i(opcode_i),
		.funct3_i(funct3_i), .funct7_i(funct7_i), .rs1_addr_i(rs1_addr_i),
		.rs2_addr_i(rs2_addr_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
		.rd_addr_i(rd_addr_i), .wreg_i(wreg_i), .imm_i(imm_i), .pc_i(pc_i),
		.mem_wdata_i(mem_wdata_i), .mem_rd_addr_i(mem_rd_addr_i), .mem_wreg_i(mem_wreg_i),
		.valid_o(valid_o), .rd_addr_o(rd_addr_o), .wreg_o(wreg_o), .wdata_o(wdata_o),
		.branch_flag_o(branch_flag_o), .pc_new_o(pc_new_o));

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
		$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		$display("Test FAILED");
		$fatal(1, "output mismatch");
	endtask

	task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
		if (act !== exp)
			value_error(name, exp, act);
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			value_error(name, exp, act);
	endtask

	task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp)
			value_error(name, 64'(exp), 64'(act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			value_error(name, 64'(exp), 64'(act));
	endtask

	task automatic check_outputs(input logic exp_valid);
		check_bit("valid_o", exp_valid, valid_o);
		check_reg("rd_addr_o", exp_rd, rd_addr_o);
		check_data("wdata_o", exp_wdata, wdata_o);
		check_bit("wreg_o", exp_wreg, wreg_o);
		check_bit("branch_flag_o", exp_br, branch_flag_o);
		check_addr("pc_new_o", exp_pc, pc_new_o);
	endtask

	// new operand values while no strobe is present
	task automatic scramble_inputs();
		rs1_data_i = {$random(seed), $random(seed)};
		rs2_data_i = {$random(seed), $random(seed)};
		pc_i       = {$random(seed), $random(seed)};
		imm_i      = 20'($random(seed));
		rd_addr_i  = 5'($random(seed));
		wreg_i     = ~wreg_i;
	endtask

	// fields are padded to whole hex digits in the pattern file
	task automatic drive_vector(input int idx);
		logic [7:0]  op;
		logic [3:0]  f3;
		logic [7:0]  f7, a1, a2, rd, mrd;
		logic [63:0] d1, d2, pc, md, ew, ep;
		logic [3:0]  w, mw, eww, ebb;
		logic [19:0] imm;
		{op, f3, f7, a1, a2, d1, d2, rd, w, imm, pc, md, mrd, mw, ew, eww, ebb, ep} = patterns[idx];
		opcode_i      = op[6:0];
		funct3_i      = f3[2:0];
		funct7_i      = f7[6:0];
		rs1_addr_i    = a1[4:0];
		rs2_addr_i    = a2[4:0];
		rs1_data_i    = d1;
		rs2_data_i    = d2;
		rd_addr_i     = rd[4:0];
		wreg_i        = w[0];
		imm_i         = imm;
		pc_i          = pc;
		mem_wdata_i   = md;
		mem_rd_addr_i = mrd[4:0];
		mem_wreg_i    = mw[0];
		valid_i       = 1'b1;
		exp_rd        = rd[4:0];
		exp_wdata     = ew;
		exp_wreg      = eww[0];
		exp_br        = ebb[0];
		exp_pc        = ep;
	endtask

	initial begin
		rst_n_i = 1'b0;
		valid_i = 1'b0;
		{opcode_i, funct3_i, funct7_i, rs1_addr_i, rs2_addr_i} = '0;
		{rs1_data_i, rs2_data_i, rd_addr_i, wreg_i, imm_i, pc_i} = '0;
		{mem_wdata_i, mem_rd_addr_i, mem_wreg_i} = '0;
		exp_rd    = REG_ZERO;
		exp_wdata = '0;
		exp_wreg  = 1'b0;
		exp_br    = 1'b0;
		exp_pc    = INVALID_PC;
		$readmemh("tests/ex_patterns.hex", patterns);
		repeat (10) @(posedge clk);
		@(negedge clk);
		check_outputs(1'b0);   // reset values
		rst_n_i = 1'b1;
		scramble_inputs();
		@(negedge clk);
		check_outputs(1'b0);
		for (int i = 0; i < NUM_VEC; i++) begin
			drive_vector(i);
			@(negedge clk);
			check_outputs(1'b1);
			valid_i = 1'b0;
			scramble_inputs();
			gap = $random(seed) & 3;   // 0 gives back-to-back strobes
			repeat (gap) begin
				@(negedge clk);
				check_outputs(1'b0);   // outputs hold
			end
		end
		@(negedge clk);
		check_outputs(1'b0);
		if (ex_top_inst.u_assert.fail_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Test FAILED");
			$fatal(1, "assertion failures during the run");
		end
	end

	initial begin
		#(WATCHDOG);
		$display("Timeout: the run did not finish within the expected time");
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* tests/ex_patterns.hex */
// op_f3_f7_rs1a_rs2a_rs1d_rs2d_rd_wreg_imm_pc_memwdata_memrd_memwreg
// then expected wdata_wreg_branch_pcnew
33_0_00_01_02_0000000000000005_0000000000000003_05_1_00000_0000000000001000_0000000000000000_00_0_0000000000000008_1_0_0000000000000000
33_0_20_01_02_0000000000000003_0000000000000005_05_1_00000_0000000000001000_0000000000000000_00_0_FFFFFFFFFFFFFFFE_1_0_0000000000000000
33_5_20_01_02_8000000000000000_0000000000000004_0a_1_00000_0000000000001000_0000000000000000_00_0_F800000000000000_1_0_0000000000000000
33_1_00_01_02_0000000000000001_000000000000003F_05_1_00000_0000000000001000_0000000000000000_00_0_8000000000000000_1_0_0000000000000000
33_7_00_01_02_00000000FF00FF00_0000000000FFFF00_05_1_00000_0000000000001000_0000000000000000_00_0_000000000000FF00_1_0_0000000000000000
13_0_00_01_02_0000000000000010_0000000000000000_05_1_00FFF_0000000000001000_0000000000000000_00_0_000000000000000F_1_0_0000000000000000
13_2_00_01_02_FFFFFFFFFFFFFFFE_0000000000000000_05_1_00001_0000000000001000_0000000000000000_00_0_0000000000000001_1_0_0000000000000000
13_3_00_01_02_0000000000000005_0000000000000000_05_1_00FFF_0000000000001000_0000000000000000_00_0_0000000000000001_1_0_0000000000000000
13_2_00_01_02_0000000000000005_0000000000000000_05_1_00FFF_0000000000001000_0000000000000000_00_0_0000000000000000_1_0_0000000000000000
13_5_20_01_02_8000000000000000_0000000000000000_05_1_00404_0000000000001000_0000000000000000_00_0_F800000000000000_1_0_0000000000000000
13_5_01_01_02_8000000000000000_0000000000000000_05_1_00021_0000000000001000_0000000000000000_00_0_0000000040000000_1_0_0000000000000000
13_4_00_01_02_0000000000000000_0000000000000000_05_1_00800_0000000000001000_0000000000000000_00_0_FFFFFFFFFFFFF800_1_0_0000000000000000
1b_0_00_01_02_000000007FFFFFFF_0000000000000000_05_1_00001_0000000000001000_0000000000000000_00_0_FFFFFFFF80000000_1_0_0000000000000000
1b_1_00_01_02_0000000000000001_0000000000000000_05_1_0001F_0000000000001000_0000000000000000_00_0_FFFFFFFF80000000_1_0_0000000000000000
1b_5_21_01_02_0000000000000000_0000000000000000_05_1_00421_0000000000001000_0000000000000000_00_0_0000000000000000_0_0_0000000000000000
1b_5_01_01_02_0000000000000000_0000000000000000_05_1_00021_0000000000001000_0000000000000000_00_0_0000000000000000_0_0_0000000000000000
1b_5_20_01_02_0000000080000000_0000000000000000_05_1_00404_0000000000001000_0000000000000000_00_0_FFFFFFFFF8000000_1_0_0000000000000000
1b_5_00_01_02_FFFFFFFF80000000_0000000000000000_05_1_00004_0000000000001000_0000000000000000_00_0_0000000008000000_1_0_0000000000000000
3b_0_20_01_02_0000000000000000_0000000000000001_05_1_00000_0000000000001000_0000000000000000_00_0_FFFFFFFFFFFFFFFF_1_0_0000000000000000
3b_5_20_01_02_0000000080000000_0000000000000021_05_1_00000_0000000000001000_0000000000000000_00_0_FFFFFFFFC0000000_1_0_0000000000000000
37_0_00_00_00_0000000000000000_0000000000000000_05_1_80000_0000000000001000_0000000000000000_00_0_FFFFFFFF80000000_1_0_0000000000000000
17_0_00_00_00_0000000000000000_0000000000000000_05_1_00001_0000000000001000_0000000000000000_00_0_0000000000002000_1_0_0000000000000000
6f_0_00_00_00_0000000000000000_0000000000000000_01_1_00010_0000000000001000_0000000000000000_00_0_0000000000001004_1_1_0000000000001020
67_0_00_01_00_0000000000002001_0000000000000000_01_1_00004_0000000000001000_0000000000000000_00_0_0000000000001004_1_1_0000000000002004
63_0_00_01_02_0000000000000007_0000000000000007_00_0_00008_0000000000001000_0000000000000000_00_0_0000000000000000_0_1_0000000000001010
63_1_00_01_02_0000000000000007_0000000000000007_00_0_00FFC_0000000000001000_0000000000000000_00_0_0000000000000000_0_0_0000000000000FF8
63_4_00_01_02_FFFFFFFFFFFFFFFF_0000000000000001_00_0_00008_0000000000001000_0000000000000000_00_0_0000000000000000_0_1_0000000000001010
63_6_00_01_02_FFFFFFFFFFFFFFFF_0000000000000001_00_0_00008_0000000000001000_0000000000000000_00_0_0000000000000000_0_0_0000000000001010
63_5_00_01_02_0000000000000001_FFFFFFFFFFFFFFFF_00_0_00008_0000000000001000_0000000000000000_00_0_0000000000000000_0_1_0000000000001010
63_7_00_01_02_0000000000000001_FFFFFFFFFFFFFFFF_00_0_00008_0000000000001000_0000000000000000_00_0_0000000000000000_0_0_0000000000001010
33_0_00_03_04_0000000000000001_0000000000000002_05_1_00000_0000000000001000_0000000000000100_03_1_0000000000000102_1_0_0000000000000000
33_0_00_03_04_0000000000000001_0000000000000002_05_1_00000_0000000000001000_0000000000000100_04_1_0000000000000101_1_0_0000000000000000
33_0_00_04_04_0000000000000001_0000000000000002_05_1_00000_0000000000001000_0000000000000100_04_1_0000000000000200_1_0_0000000000000000
33_0_00_00_00_0000000000000001_0000000000000002_05_1_00000_0000000000001000_0000000000000100_00_1_0000000000000003_1_0_0000000000000000
33_0_00_03_04_0000000000000001_0000000000000002_05_1_00000_0000000000001000_0000000000000100_03_0_0000000000000003_1_0_0000000000000000
7f_0_00_01_02_0000000000000001_0000000000000002_05_1_00000_0000000000001000_0000000000000000_00_0_0000000000000000_1_0_0000000000000000

/* compile.f */
source/ex_pkg.sv
source/ex_operand_fwd.sv
source/ex_alu.sv
source/ex_branch.sv
source/ex_out_reg.sv
source/ex_top.sv
tests/ex_top_assert.sv
tests/tb_ex_top.sv
